/* attn_defines.svh */
// Size, shift and clamp constants of the attention scoring head.
// Included by the package and by every module that needs the sizes.
`ifndef ATTN_DEFINES_SVH
`define ATTN_DEFINES_SVH

// Inner dimension and length of every row
`define ATTN_DIM 4

// Key rows held by the matmul
`define ATTN_TOKENS 4

// Parallel dot-product cores, equal to the scores per block
`define ATTN_CORES 2

// Blocks per score row
`define ATTN_BLOCKS (`ATTN_DIM / `ATTN_CORES)

// Arithmetic right shift applied to each raw dot product
`define ATTN_SHIFT 4

// Largest distance from the row maximum the exponent table resolves
`define ATTN_EXP_CLAMP 15

`endif

/* attn_pkg.sv */
// Shared element, accumulator and row types of the attention scoring head.
// Imported by the RTL modules and the testbench.
`default_nettype none

package attn_pkg;

    `include "attn_defines.svh"

    // Query, key and scaled score element
    typedef logic signed [7:0] elem_t;

    // Sum of ATTN_DIM products of two elements
    typedef logic signed [17:0] acc_t;

    // Exponent table value and probability
    typedef logic [7:0] exp_t;
    typedef logic [7:0] prob_t;

    // Sum of four exponents, at most 4 * 255
    typedef logic [9:0] sum_t;

    typedef elem_t [`ATTN_DIM-1:0] vec_t;
    typedef elem_t [`ATTN_CORES-1:0] block_t;
    typedef prob_t [`ATTN_DIM-1:0] prob_row_t;

    // Key row index
    typedef logic [1:0] tok_idx_t;

endpackage

`default_nettype wire

/* qk_matmul.sv */
// Score product Q*K^T with the key matrix in registers and two dot-product cores.
// Each start yields two blocks of scaled, saturated scores on consecutive cycles.
`timescale 1ns/1ns
`default_nettype none

`include "attn_defines.svh"

module qk_matmul import attn_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     k_load,
    input  tok_idx_t k_row_idx,
    input  vec_t     k_row,
    input  logic     start,
    input  vec_t     q_row,
    output logic     blk_valid,
    output logic     blk_idx,
    output block_t   blk_scores
);

    localparam acc_t SAT_MAX = 127;
    localparam acc_t SAT_MIN = -128;

    vec_t   keys [`ATTN_TOKENS];
    vec_t   q_reg;
    logic   pend;
    logic   ph;
    logic   accept;
    acc_t   core_sum [`ATTN_CORES];
    block_t sat_next;

    function automatic acc_t dot_product(input vec_t a, input vec_t b);
        acc_t acc;
        acc = '0;
        for (int i = 0; i < `ATTN_DIM; i++) begin
            acc = acc + acc_t'($signed(a[i])) * acc_t'($signed(b[i]));
        end
        return acc;
    endfunction

    // Round half up, shift, then clamp into a signed byte
    function automatic elem_t scale_sat(input acc_t s);
        acc_t r;
        r = (s + acc_t'(1 << (`ATTN_SHIFT - 1))) >>> `ATTN_SHIFT;
        if (r > SAT_MAX) begin
            return elem_t'(SAT_MAX);
        end else if (r < SAT_MIN) begin
            return elem_t'(SAT_MIN);
        end
        return elem_t'(r);
    endfunction

    // A new query is taken unless block 0 is still pending
    assign accept = start && !(pend && !ph);

    always_comb begin
        for (int c = 0; c < `ATTN_CORES; c++) begin
            core_sum[c] = dot_product(q_reg, keys[ph * `ATTN_CORES + c]);
            sat_next[c] = scale_sat(core_sum[c]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < `ATTN_TOKENS; t++) begin
                keys[t] <= '0;
            end
        end else if (k_load) begin
            keys[k_row_idx] <= k_row;
        end
    end

    // Block sequencing, ph selects which key rows feed the cores
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend      <= 1'b0;
            ph        <= 1'b0;
            blk_valid <= 1'b0;
            blk_idx   <= 1'b0;
        end else begin
            blk_valid <= pend;
            blk_idx   <= ph;
            if (pend && !ph) begin
                ph <= 1'b1;
            end else begin
                pend <= start;
                ph   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            q_reg <= q_row;
        end
        if (pend) begin
            blk_scores <= sat_next;
        end
    end

endmodule

`default_nettype wire

/* b2r_converter.sv */
// Gathers score blocks into one full score row and strobes it.
// The output row holds until the next row is complete.
`timescale 1ns/1ns
`default_nettype none

`include "attn_defines.svh"

module b2r_converter import attn_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   blk_valid,
    input  logic   blk_idx,
    input  block_t blk_scores,
    output logic   row_valid,
    output vec_t   row_scores
);

    // Earlier blocks wait here while the row is incomplete
    block_t stage [`ATTN_BLOCKS-1];
    logic   last_blk;

    assign last_blk = (blk_idx == 1'(`ATTN_BLOCKS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_valid <= 1'b0;
        end else begin
            row_valid <= blk_valid && last_blk;
        end
    end

    always_ff @(posedge clk) begin
        if (blk_valid) begin
            if (!last_blk) begin
                stage[blk_idx] <= blk_scores;
            end else begin
                for (int b = 0; b < `ATTN_BLOCKS - 1; b++) begin
                    for (int c = 0; c < `ATTN_CORES; c++) begin
                        row_scores[b * `ATTN_CORES + c] <= stage[b][c];
                    end
                end
                // Final block goes straight into the top of the row
                for (int c = 0; c < `ATTN_CORES; c++) begin
                    row_scores[(`ATTN_BLOCKS - 1) * `ATTN_CORES + c] <= blk_scores[c];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* softmax_row.sv */
// Row softmax in fixed point with an exponent table and one shared divider.
// Probabilities are scaled to 256 and saturate at 255.
`timescale 1ns/1ns
`default_nettype none

`include "attn_defines.svh"

module softmax_row import attn_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      row_valid,
    input  vec_t      row_scores,
    output logic      out_valid,
    output prob_row_t out_prob,
    output logic      active
);

    localparam int IDX_W     = $clog2(`ATTN_DIM);
    localparam int DIV_STEPS = 16;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_DIV
    } state_t;

    state_t           state;
    vec_t             scores;
    elem_t            row_max;
    elem_t            max_next;
    exp_t             e_reg [`ATTN_DIM];
    exp_t             e_next [`ATTN_DIM];
    sum_t             sum_reg;
    sum_t             sum_next;
    logic [15:0]      quo;
    logic [15:0]      quo_next;
    sum_t             rem;
    sum_t             rem_next;
    logic [10:0]      shifted;
    logic [11:0]      trial;
    logic             q_bit;
    prob_t            prob_next;
    logic [3:0]       step;
    logic [IDX_W-1:0] el_idx;
    logic             last_step;
    logic             last_elem;

    // round(255 * exp(-d / 4))
    function automatic exp_t exp_lut(input logic [3:0] d);
        case (d)
            4'd0:    return 8'd255;
            4'd1:    return 8'd199;
            4'd2:    return 8'd155;
            4'd3:    return 8'd120;
            4'd4:    return 8'd94;
            4'd5:    return 8'd73;
            4'd6:    return 8'd57;
            4'd7:    return 8'd44;
            4'd8:    return 8'd35;
            4'd9:    return 8'd27;
            4'd10:   return 8'd21;
            4'd11:   return 8'd16;
            4'd12:   return 8'd13;
            4'd13:   return 8'd10;
            4'd14:   return 8'd8;
            default: return 8'd6;
        endcase
    endfunction

    always_comb begin
        max_next = row_scores[0];
        for (int j = 1; j < `ATTN_DIM; j++) begin
            if ($signed(row_scores[j]) > $signed(max_next)) begin
                max_next = row_scores[j];
            end
        end
    end

    // Distance to the maximum, clamped to the table range
    always_comb begin
        logic signed [8:0] diff;
        sum_next = '0;
        for (int j = 0; j < `ATTN_DIM; j++) begin
            diff = $signed({row_max[7], row_max}) - $signed({scores[j][7], scores[j]});
            if (diff > 9'sd`ATTN_EXP_CLAMP) begin
                e_next[j] = exp_lut(4'(`ATTN_EXP_CLAMP));
            end else begin
                e_next[j] = exp_lut(diff[3:0]);
            end
            sum_next = sum_next + sum_t'(e_next[j]);
        end
    end

    // One restoring division step of e * 256 by the row sum
    always_comb begin
        shifted   = {rem, quo[15]};
        trial     = {1'b0, shifted} - {2'b00, sum_reg};
        q_bit     = !trial[11];
        rem_next  = q_bit ? trial[9:0] : shifted[9:0];
        quo_next  = {quo[14:0], q_bit};
        prob_next = (quo_next > 16'd255) ? 8'd255 : quo_next[7:0];
    end

    assign last_step = (step == 4'(DIV_STEPS - 1));
    assign last_elem = (el_idx == IDX_W'(`ATTN_DIM - 1));
    assign active    = row_valid || (state != ST_IDLE) || out_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            step      <= '0;
            el_idx    <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (row_valid) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    state  <= ST_DIV;
                    step   <= '0;
                    el_idx <= '0;
                end
                ST_DIV: begin
                    step <= step + 4'd1;
                    if (last_step) begin
                        if (last_elem) begin
                            state     <= ST_IDLE;
                            out_valid <= 1'b1;
                        end else begin
                            el_idx <= el_idx + 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && row_valid) begin
            scores  <= row_scores;
            row_max <= max_next;
        end
        if (state == ST_LOOKUP) begin
            e_reg   <= e_next;
            sum_reg <= sum_next;
            quo     <= {e_next[0], 8'd0};
            rem     <= '0;
        end
        if (state == ST_DIV) begin
            if (last_step) begin
                out_prob[el_idx] <= prob_next;
                // Load the next dividend for the following element
                if (!last_elem) begin
                    quo <= {e_reg[el_idx + 1'b1], 8'd0};
                    rem <= '0;
                end
            end else begin
                quo <= quo_next;
                rem <= rem_next;
            end
        end
    end

endmodule

`default_nettype wire

/* attn_score_head.sv */
// Top level of the attention scoring path: matmul, block to row, softmax.
// The host loads keys, sends queries while busy is low and reads both rows.
`timescale 1ns/1ns
`default_nettype none

module attn_score_head import attn_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      k_load,
    input  tok_idx_t  k_row_idx,
    input  vec_t      k_row,
    input  logic      q_valid,
    input  vec_t      q_row,
    output logic      busy,
    output logic      score_valid,
    output vec_t      score_row,
    output logic      out_valid,
    output prob_row_t out_prob
);

    logic   in_flight;
    logic   q_accept;
    logic   k_load_ok;
    logic   blk_valid;
    logic   blk_idx;
    block_t blk_scores;
    logic   row_valid;
    vec_t   row_scores;
    logic   sm_active;
    logic   sm_active_d;

    // Keys and queries only pass while nothing is in flight
    assign q_accept  = q_valid && !in_flight;
    assign k_load_ok = k_load && !in_flight;
    assign busy      = in_flight;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight   <= 1'b0;
            sm_active_d <= 1'b0;
        end else begin
            sm_active_d <= sm_active;
            if (q_accept) begin
                in_flight <= 1'b1;
            end else if (sm_active_d && !sm_active) begin
                // Softmax just finished its row
                in_flight <= 1'b0;
            end
        end
    end

    qk_matmul u_matmul (
        .clk        (clk),
        .rst_n      (rst_n),
        .k_load     (k_load_ok),
        .k_row_idx  (k_row_idx),
        .k_row      (k_row),
        .start      (q_accept),
        .q_row      (q_row),
        .blk_valid  (blk_valid),
        .blk_idx    (blk_idx),
        .blk_scores (blk_scores)
    );

    b2r_converter u_b2r (
        .clk        (clk),
        .rst_n      (rst_n),
        .blk_valid  (blk_valid),
        .blk_idx    (blk_idx),
        .blk_scores (blk_scores),
        .row_valid  (row_valid),
        .row_scores (row_scores)
    );

    softmax_row u_softmax (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_valid  (row_valid),
        .row_scores (row_scores),
        .out_valid  (out_valid),
        .out_prob   (out_prob),
        .active     (sm_active)
    );

    // Scaled score row is visible to the host as well
    assign score_valid = row_valid;
    assign score_row   = row_scores;

endmodule

`default_nettype wire

/* tb_attn_score_head.sv */
// Replays attn_cases.txt against the attention scoring head DUT.
// Checks score rows, probability rows, score latency and the busy rule.
`timescale 1ns/1ns
`default_nettype none

`include "attn_defines.svh"

module tb_attn_score_head import attn_pkg::*; ();

    localparam int WAIT_LIMIT    = 200;
    localparam int SCORE_LATENCY = 3;

    logic      clk;
    logic      rst_n;
    logic      k_load;
    tok_idx_t  k_row_idx;
    vec_t      k_row;
    logic      q_valid;
    vec_t      q_row;
    logic      busy;
    logic      score_valid;
    vec_t      score_row;
    logic      out_valid;
    prob_row_t out_prob;

    integer seed = 32'h02efb463;
    int     score_errors = 0;
    int     prob_errors  = 0;
    int     flag_errors  = 0;
    int     proto_errors = 0;
    int     score_count  = 0;
    int     out_count    = 0;
    int     case_no      = 0;

    attn_score_head attn_score_head_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .k_load      (k_load),
        .k_row_idx   (k_row_idx),
        .k_row       (k_row),
        .q_valid     (q_valid),
        .q_row       (q_row),
        .busy        (busy),
        .score_valid (score_valid),
        .score_row   (score_row),
        .out_valid   (out_valid),
        .out_prob    (out_prob)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Each single-cycle strobe is seen on exactly one rising edge
    always @(posedge clk) begin
        if (score_valid) begin
            score_count <= score_count + 1;
        end
        if (out_valid) begin
            out_count <= out_count + 1;
        end
    end

    task automatic check_scores(input vec_t got, input vec_t exp_row);
        for (int i = 0; i < `ATTN_DIM; i++) begin
            if (got[i] !== exp_row[i]) begin
                $display("CHECK FAILED at %0t: query %0d score %0d is %0d, expected %0d",
                         $time, case_no, i, $signed(got[i]), $signed(exp_row[i]));
                score_errors++;
            end
        end
    endtask

    task automatic check_probs(input prob_row_t got, input prob_row_t exp_row);
        for (int i = 0; i < `ATTN_DIM; i++) begin
            if (got[i] !== exp_row[i]) begin
                $display("CHECK FAILED at %0t: query %0d probability %0d is %0d, expected %0d",
                         $time, case_no, i, got[i], exp_row[i]);
                prob_errors++;
            end
        end
    endtask

    task automatic check_flag(input logic got, input logic exp_val, input string what);
        if (got !== exp_val) begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp_val);
            flag_errors++;
        end
    endtask

    // Counts edges from the accepting edge until the row shows up
    task automatic wait_score(output int cycles, output logic ok);
        cycles = 0;
        @(negedge clk);
        ok = score_valid;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            ok = score_valid;
        end
        if (!ok) begin
            $display("Timeout: no score row for query %0d within %0d cycles", case_no,
                     WAIT_LIMIT);
            proto_errors++;
        end
    endtask

    task automatic wait_out(output logic ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            ok = out_valid;
        end
        if (!ok) begin
            $display("Timeout: no probability row for query %0d within %0d cycles", case_no,
                     WAIT_LIMIT);
            proto_errors++;
        end
    endtask

    task automatic wait_idle(output logic ok);
        int cycles;
        cycles = 0;
        ok = !busy;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            ok = !busy;
        end
        if (!ok) begin
            $display("Timeout: busy stayed high after query %0d for %0d cycles", case_no,
                     WAIT_LIMIT);
            proto_errors++;
        end
    endtask

    task automatic load_key(input tok_idx_t idx, input vec_t row);
        @(posedge clk);
        k_load    <= 1'b1;
        k_row_idx <= idx;
        k_row     <= row;
        @(posedge clk);
        k_load <= 1'b0;
    endtask

    task automatic run_query(input vec_t q, input vec_t exp_s, input prob_row_t exp_p,
                             input logic intrude);
        int   gap;
        int   lat;
        int   sc0;
        int   oc0;
        logic ok;
        gap = $unsigned($random(seed)) % 8;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        q_valid <= 1'b1;
        q_row   <= q;
        sc0 = score_count;
        oc0 = out_count;
        @(posedge clk);
        q_valid <= 1'b0;
        wait_score(lat, ok);
        if (!ok) begin
            return;
        end
        if (lat != SCORE_LATENCY) begin
            $display("CHECK FAILED at %0t: query %0d score row after %0d cycles, expected %0d",
                     $time, case_no, lat, SCORE_LATENCY);
            proto_errors++;
        end
        check_scores(score_row, exp_s);
        // A second query and a key load while the softmax runs must leave no trace
        if (intrude) begin
            check_flag(busy, 1'b1, "busy before the ignored query");
            @(posedge clk);
            q_valid   <= 1'b1;
            q_row     <= ~q;
            k_load    <= 1'b1;
            k_row_idx <= '0;
            k_row     <= ~q;
            @(posedge clk);
            q_valid <= 1'b0;
            k_load  <= 1'b0;
        end
        wait_out(ok);
        if (!ok) begin
            return;
        end
        check_probs(out_prob, exp_p);
        wait_idle(ok);
        if (score_count != sc0 + 1 || out_count != oc0 + 1) begin
            $display("CHECK FAILED at %0t: query %0d gave %0d score and %0d probability rows",
                     $time, case_no, score_count - sc0, out_count - oc0);
            proto_errors++;
        end
    endtask

    initial begin : main
        integer           fd;
        integer           code;
        integer           kind;
        integer           f [0:11];
        logic [8*160-1:0] line;
        logic             done;
        vec_t             kv;
        vec_t             qv;
        vec_t             sv;
        prob_row_t        pv;
        k_load    = 1'b0;
        k_row_idx = '0;
        k_row     = '0;
        q_valid   = 1'b0;
        q_row     = '0;
        rst_n     = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(score_valid, 1'b0, "score_valid after reset");
        check_flag(out_valid, 1'b0, "out_valid after reset");

        fd = $fopen("attn_cases.txt", "r");
        done = (fd == 0);
        if (fd == 0) begin
            $display("Could not open the case file attn_cases.txt");
            proto_errors++;
        end
        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(line, fd);
            end else if (kind == "K") begin
                code = $fscanf(fd, "%d %d %d %d %d", f[0], f[1], f[2], f[3], f[4]);
                if (code != 5) begin
                    $display("Malformed key line in the case file");
                    proto_errors++;
                    done = 1'b1;
                end else begin
                    for (int i = 0; i < `ATTN_DIM; i++) begin
                        kv[i] = elem_t'(f[1 + i]);
                    end
                    load_key(tok_idx_t'(f[0]), kv);
                end
            end else if (kind == "Q" || kind == "B") begin
                code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d %d", f[0], f[1], f[2],
                               f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
                if (code != 12) begin
                    $display("Malformed query line in the case file");
                    proto_errors++;
                    done = 1'b1;
                end else begin
                    for (int i = 0; i < `ATTN_DIM; i++) begin
                        qv[i] = elem_t'(f[i]);
                        sv[i] = elem_t'(f[4 + i]);
                        pv[i] = prob_t'(f[8 + i]);
                    end
                    case_no++;
                    run_query(qv, sv, pv, kind == "B");
                end
            end else begin
                $display("Unknown line type in the case file");
                proto_errors++;
                done = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Queries %0d, errors: %0d score, %0d probability, %0d flag, %0d protocol",
                 case_no, score_errors, prob_errors, flag_errors, proto_errors);
        if (score_errors + prob_errors + flag_errors + proto_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* attn_cases.txt */
# K idx k0 k1 k2 k3 loads a key row. Q q0 q1 q2 q3 s0 s1 s2 s3 p0 p1 p2 p3 sends a query
# with expected scores and probabilities. B is a Q that also gets an ignored query while busy
Q 5 -3 7 1 0 0 0 0 64 64 64 64
K 0 1 0 0 0
K 1 0 1 0 0
K 2 100 100 100 100
K 3 -100 100 -100 100
Q 8 -8 1 0 1 0 6 -106 47 37 166 3
Q 7 -9 127 -128 0 -1 -19 -128 140 109 3 3
Q -8 7 127 127 0 0 127 94 5 5 239 5
Q 20 -20 0 1 1 -1 6 -128 49 29 172 4
K 2 2 2 2 2
K 3 -3 1 4 -1
Q 40 -24 10 16 3 -1 5 -7 82 30 136 6
K 0 0 0 0 16
Q 40 -24 10 16 16 -1 5 -7 230 5 14 5
B -16 16 8 8 8 1 2 6 127 22 28 77
K 1 0 0 0 16
K 2 0 0 0 16
K 3 0 0 0 16
Q 5 -7 9 100 100 100 100 100 64 64 64 64
Q 1 2 3 -100 -100 -100 -100 -100 64 64 64 64
K 1 1 -1 1 -1
K 2 -128 -128 -128 -128
K 3 127 0 -128 5
Q -128 -128 -128 -128 -128 0 127 -32 5 5 239 5
B 127 127 127 127 127 0 -128 32 239 5 5 5
Q 3 -5 2 1 1 1 -8 8 32 32 4 187

/* sources.f */
+incdir+.
attn_pkg.sv
qk_matmul.sv
b2r_converter.sv
softmax_row.sv
attn_score_head.sv
tb_attn_score_head.sv

/* Bender.yml */
package:
  name: attn_score_head

export_include_dirs:
  - .

sources:
  - attn_pkg.sv
  - qk_matmul.sv
  - b2r_converter.sv
  - softmax_row.sv
  - attn_score_head.sv
  - target: test
    files:
      - tb_attn_score_head.sv
